/* logic/mfp_ahb_pkg.sv */
package mfp_ahb_pkg;

    // --------------------
    // Bus words and codes
    // --------------------

    typedef logic [31:0] ahb_word_t;

    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_BUSY   = 2'b01;
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
    localparam logic [1:0] HTRANS_SEQ    = 2'b11;

    localparam logic [2:0] HSIZE_BYTE = 3'b000;
    localparam logic [2:0] HSIZE_HALF = 3'b001;
    localparam logic [2:0] HSIZE_WORD = 3'b010;

    // Two decodings of the same HADDR
    typedef struct packed {
        logic [2:0]  seg;      // Kseg bits, ignored by the decoder
        logic [6:0]  page;     // 4 MB pages
        logic [21:0] offset;
    } ahb_page_view_t;

    typedef struct packed {
        logic [2:0]  seg;
        logic [2:0]  window;   // 64 MB windows
        logic [25:0] offset;
    } ahb_ram_view_t;

    typedef union packed {
        ahb_page_view_t page_view;
        ahb_ram_view_t  ram_view;
    } ahb_addr_u;

    // --------------------
    // Memory map
    // --------------------

    localparam logic [6:0] RESET_RAM_PAGE = 7'h7f;  // 0x1fc00000
    localparam logic [6:0] GPIO_PAGE      = 7'h7e;  // 0x1f800000
    localparam logic [2:0] RAM_WINDOW     = 3'b000; // 0x00000000

    localparam int RESET_RAM_ADDR_WIDTH = 8;
    localparam int RAM_ADDR_WIDTH       = 10;

    localparam int N_DEVICES     = 3;
    localparam int DEV_RESET_RAM = 0;
    localparam int DEV_RAM       = 1;
    localparam int DEV_GPIO      = 2;
    localparam int DEV_NONE      = 3;  // Unmapped, answered with ERROR

    typedef logic [N_DEVICES:0] dev_sel_t;

    typedef struct packed {
        ahb_addr_u  haddr;
        logic [1:0] htrans;
        logic [2:0] hsize;
        logic       hwrite;
    } ahb_req_t;

    typedef struct packed {
        ahb_word_t hrdata;
        logic      hready;
        logic      hresp;
    } ahb_rsp_t;

    // --------------------
    // GPIO
    // --------------------

    localparam int N_SWITCHES   = 10;
    localparam int N_BUTTONS    = 4;
    localparam int N_RED_LEDS   = 10;
    localparam int N_GREEN_LEDS = 8;
    localparam int HEX_WIDTH    = 24;

    typedef struct packed {
        logic [N_SWITCHES-1:0] switches;
        logic [N_BUTTONS-1:0]  buttons;
    } gpio_in_t;

    typedef struct packed {
        logic [N_RED_LEDS-1:0]   red_leds;
        logic [N_GREEN_LEDS-1:0] green_leds;
        logic [HEX_WIDTH-1:0]    hex;
    } gpio_out_t;

    // Word offsets, HADDR[5:2]
    localparam logic [3:0] GPIO_RED      = 4'd0;
    localparam logic [3:0] GPIO_GREEN    = 4'd1;
    localparam logic [3:0] GPIO_HEX      = 4'd2;
    localparam logic [3:0] GPIO_SWITCHES = 4'd3;
    localparam logic [3:0] GPIO_BUTTONS  = 4'd4;

endpackage

/* logic/mfp_ahb_lite_decoder.sv */
module mfp_ahb_lite_decoder
    import mfp_ahb_pkg::*;
(
    input  ahb_req_t req,
    output dev_sel_t sel
);

    logic active;

    always_comb begin
        active = 1'b0;
        case (req.htrans)
            HTRANS_NONSEQ, HTRANS_SEQ: active = 1'b1;
            HTRANS_IDLE, HTRANS_BUSY:  active = 1'b0;  // No transfer, no select
        endcase
    end

    always_comb begin
        sel = '0;
        if (active) begin
            // Reset RAM 4 MB at 0x1fc00000
            sel[DEV_RESET_RAM] = (req.haddr.page_view.page == RESET_RAM_PAGE);
            // Main RAM 64 MB at 0x00000000
            sel[DEV_RAM]       = (req.haddr.ram_view.window == RAM_WINDOW);
            // GPIO 4 MB at 0x1f800000
            sel[DEV_GPIO]      = (req.haddr.page_view.page == GPIO_PAGE);

            // Nothing matched
            sel[DEV_NONE] = ~|sel[N_DEVICES-1:0];
        end
    end

endmodule

/* logic/mfp_ahb_lite_response_mux.sv */
module mfp_ahb_lite_response_mux
    import mfp_ahb_pkg::*;
(
    input  logic      hclk,
    input  logic      rst_n,
    input  dev_sel_t  sel,
    input  ahb_word_t rdata_reset_ram,
    input  ahb_word_t rdata_ram,
    input  ahb_word_t rdata_gpio,
    output ahb_rsp_t  rsp
);

    dev_sel_t  sel_r;     // Data phase select
    logic      err_last;  // Second cycle of the ERROR response
    logic      hready;
    ahb_word_t hrdata;

    // --------------------
    // Data phase tracking
    // --------------------

    always_ff @(posedge hclk) begin
        if (!rst_n) begin
            sel_r <= '0;
        end else if (hready) begin
            sel_r <= sel;
        end
    end

    always_ff @(posedge hclk) begin
        if (!rst_n) begin
            err_last <= 1'b0;
        end else begin
            err_last <= sel_r[DEV_NONE] && !err_last;
        end
    end

    // First error cycle stalls the master, second one completes it
    assign hready = !(sel_r[DEV_NONE] && !err_last);

    // --------------------
    // Read data
    // --------------------

    always_comb begin
        hrdata = '0;  // Idle and error cycles
        if (sel_r[DEV_RESET_RAM]) begin
            hrdata = rdata_reset_ram;
        end else if (sel_r[DEV_RAM]) begin
            hrdata = rdata_ram;
        end else if (sel_r[DEV_GPIO]) begin
            hrdata = rdata_gpio;
        end
    end

    always_comb begin
        rsp.hrdata = hrdata;
        rsp.hready = hready;
        rsp.hresp  = sel_r[DEV_NONE];
    end

endmodule

/* logic/ahb_lite_bram.sv */
module ahb_lite_bram
    import mfp_ahb_pkg::*;
#(
    parameter int ADDR_WIDTH = RAM_ADDR_WIDTH
)(
    input  logic      hclk,
    input  logic      rst_n,
    input  ahb_req_t  req,
    input  logic      sel,
    input  logic      hready,
    input  ahb_word_t hwdata,
    output ahb_word_t rdata
);

    ahb_word_t mem [0:2**ADDR_WIDTH-1];

    logic                  accept;
    logic [ADDR_WIDTH-1:0] addr;       // Word address, upper bits alias
    logic [3:0]            mask;

    logic                  wr_pending;
    logic [ADDR_WIDTH-1:0] wr_addr;
    logic [3:0]            wr_mask;
    logic                  wr_hit;

    ahb_word_t             mem_q;
    ahb_word_t             fwd_data_q;
    logic [3:0]            fwd_mask_q;

    // Byte lanes of a transfer, little endian
    function automatic logic [3:0] lane_mask(input logic [2:0] hsize, input logic [1:0] lsb);
        logic [3:0] m;
        case (hsize)
            HSIZE_BYTE: m = 4'b0001 << lsb;
            HSIZE_HALF: m = lsb[1] ? 4'b1100 : 4'b0011;
            HSIZE_WORD: m = 4'b1111;
            default:    m = 4'b1111;
        endcase
        return m;
    endfunction

    assign accept = sel && hready;
    assign addr   = req.haddr.ram_view.offset[ADDR_WIDTH+1:2];
    assign mask   = lane_mask(req.hsize, req.haddr.ram_view.offset[1:0]);
    assign wr_hit = wr_pending && (wr_addr == addr);

    // --------------------
    // Write path
    // --------------------

    always_ff @(posedge hclk) begin
        if (!rst_n) begin
            wr_pending <= 1'b0;
        end else if (hready) begin
            wr_pending <= accept && req.hwrite;
        end
    end

    always_ff @(posedge hclk) begin
        if (accept && req.hwrite) begin
            wr_addr <= addr;
            wr_mask <= mask;
        end
    end

    always_ff @(posedge hclk) begin
        if (wr_pending && hready) begin
            for (int i = 0; i < 4; i++) begin
                if (wr_mask[i]) begin
                    mem[wr_addr][8*i +: 8] <= hwdata[8*i +: 8];
                end
            end
        end
    end

    // --------------------
    // Read path
    // --------------------

    always_ff @(posedge hclk) begin
        if (accept && !req.hwrite) begin
            mem_q      <= mem[addr];
            fwd_data_q <= hwdata;                     // Data of the write in flight
            fwd_mask_q <= wr_hit ? wr_mask : 4'b0000;
        end
    end

    // Merge lanes written in the same cycle as the read
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            rdata[8*i +: 8] = fwd_mask_q[i] ? fwd_data_q[8*i +: 8] : mem_q[8*i +: 8];
        end
    end

endmodule

/* logic/mfp_ahb_gpio_slave.sv */
module mfp_ahb_gpio_slave
    import mfp_ahb_pkg::*;
(
    input  logic      hclk,
    input  logic      rst_n,
    input  ahb_req_t  req,
    input  logic      sel,
    input  logic      hready,
    input  ahb_word_t hwdata,
    input  gpio_in_t  io_in,
    output gpio_out_t io_out,
    output ahb_word_t rdata
);

    logic       accept;
    logic [3:0] offset;

    logic       wr_pending;
    logic [3:0] wr_offset;
    logic [3:0] rd_offset;
    gpio_in_t   in_q;       // Inputs seen at the address phase

    logic [N_RED_LEDS-1:0]   red_q;
    logic [N_GREEN_LEDS-1:0] green_q;
    logic [HEX_WIDTH-1:0]    hex_q;

    assign accept = sel && hready;
    assign offset = req.haddr.page_view.offset[5:2];

    // --------------------
    // Address phase
    // --------------------

    always_ff @(posedge hclk) begin
        if (!rst_n) begin
            wr_pending <= 1'b0;
        end else if (hready) begin
            wr_pending <= accept && req.hwrite;
        end
    end

    always_ff @(posedge hclk) begin
        if (accept) begin
            wr_offset <= offset;
            rd_offset <= offset;
            in_q      <= io_in;
        end
    end

    // --------------------
    // Output registers
    // --------------------

    always_ff @(posedge hclk) begin
        if (!rst_n) begin
            red_q   <= '0;
            green_q <= '0;
            hex_q   <= '0;
        end else if (wr_pending && hready) begin
            case (wr_offset)
                GPIO_RED:   red_q   <= hwdata[N_RED_LEDS-1:0];
                GPIO_GREEN: green_q <= hwdata[N_GREEN_LEDS-1:0];
                GPIO_HEX:   hex_q   <= hwdata[HEX_WIDTH-1:0];
                default:    ;  // Inputs are read only
            endcase
        end
    end

    assign io_out.red_leds   = red_q;
    assign io_out.green_leds = green_q;
    assign io_out.hex        = hex_q;

    // Read data, zero extended
    always_comb begin
        rdata = '0;
        case (rd_offset)
            GPIO_RED:      rdata[N_RED_LEDS-1:0]   = red_q;
            GPIO_GREEN:    rdata[N_GREEN_LEDS-1:0] = green_q;
            GPIO_HEX:      rdata[HEX_WIDTH-1:0]    = hex_q;
            GPIO_SWITCHES: rdata[N_SWITCHES-1:0]   = in_q.switches;
            GPIO_BUTTONS:  rdata[N_BUTTONS-1:0]    = in_q.buttons;
            default:       rdata = '0;
        endcase
    end

endmodule

/* logic/mfp_ahb_lite_matrix.sv */
module mfp_ahb_lite_matrix
    import mfp_ahb_pkg::*;
(
    input  logic      hclk,
    input  logic      rst_n,
    input  ahb_req_t  req,
    input  ahb_word_t hwdata,
    output ahb_rsp_t  rsp,
    input  gpio_in_t  io_in,
    output gpio_out_t io_out
);

    dev_sel_t  sel;             // Address phase selects
    ahb_word_t rdata_reset_ram;
    ahb_word_t rdata_ram;
    ahb_word_t rdata_gpio;

    mfp_ahb_lite_decoder decoder (
        .req ( req ),
        .sel ( sel )
    );

    // --------------------
    // Slaves
    // --------------------

    ahb_lite_bram #(
        .ADDR_WIDTH ( RESET_RAM_ADDR_WIDTH )
    ) reset_ram (
        .hclk   ( hclk               ),
        .rst_n  ( rst_n              ),
        .req    ( req                ),
        .sel    ( sel[DEV_RESET_RAM] ),
        .hready ( rsp.hready         ),
        .hwdata ( hwdata             ),
        .rdata  ( rdata_reset_ram    )
    );

    ahb_lite_bram #(
        .ADDR_WIDTH ( RAM_ADDR_WIDTH )
    ) ram (
        .hclk   ( hclk         ),
        .rst_n  ( rst_n        ),
        .req    ( req          ),
        .sel    ( sel[DEV_RAM] ),
        .hready ( rsp.hready   ),
        .hwdata ( hwdata       ),
        .rdata  ( rdata_ram    )
    );

    mfp_ahb_gpio_slave gpio (
        .hclk   ( hclk          ),
        .rst_n  ( rst_n         ),
        .req    ( req           ),
        .sel    ( sel[DEV_GPIO] ),
        .hready ( rsp.hready    ),
        .hwdata ( hwdata        ),
        .io_in  ( io_in         ),
        .io_out ( io_out        ),
        .rdata  ( rdata_gpio    )
    );

    // --------------------
    // Response path
    // --------------------

    mfp_ahb_lite_response_mux response_mux (
        .hclk            ( hclk            ),
        .rst_n           ( rst_n           ),
        .sel             ( sel             ),
        .rdata_reset_ram ( rdata_reset_ram ),
        .rdata_ram       ( rdata_ram       ),
        .rdata_gpio      ( rdata_gpio      ),
        .rsp             ( rsp             )
    );

endmodule

/* dv/clock_gen.sv */
module clock_gen (
    output logic hclk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 16;

    initial begin
        hclk = 1'b0;
        forever #50 hclk = ~hclk;  // 100 ns period
    end

    // Release on a falling edge, like the rest of the stimulus
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge hclk);
        @(negedge hclk);
        rst_n = 1'b1;
    end

endmodule

/* dv/tb_mfp_ahb_lite_matrix.sv */
module tb_mfp_ahb_lite_matrix
    import mfp_ahb_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 16;

    logic      hclk;
    logic      rst_n;
    ahb_req_t  req;
    ahb_word_t hwdata;
    ahb_rsp_t  rsp;
    gpio_in_t  io_in;
    gpio_out_t io_out;

    // One entry per case line
    string      names[$];
    string      ops[$];
    ahb_word_t  addrs[$];
    logic [2:0] sizes[$];
    ahb_word_t  words[$];  // Write data or expected read word
    gpio_in_t   ins[$];
    gpio_out_t  exp_outs[$];
    logic       exp_errs[$];

    int word_errors, gpio_errors, rsp_errors, other_errors;
    int cycle_count = 0;
    int cycle_limit = RESET_CYCLES + 50;
    int err_waits;                    // Cycles with hready low in this data phase
    int addr_idx, data_idx, done_idx, next_case;
    logic last_ready;                 // hready at the last rising edge

    clock_gen clock (.hclk(hclk), .rst_n(rst_n));

    mfp_ahb_lite_matrix mfp_ahb_lite_matrix_i (
        .hclk   ( hclk   ),
        .rst_n  ( rst_n  ),
        .req    ( req    ),
        .hwdata ( hwdata ),
        .rsp    ( rsp    ),
        .io_in  ( io_in  ),
        .io_out ( io_out )
    );

    // --------------------
    // Checks
    // --------------------

    task automatic compare_word(input string name, input ahb_word_t exp, input ahb_word_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: hrdata expected %08h, actual %08h", name, exp, act);
            word_errors++;
        end
    endtask

    // Fields shown as red/green/hex
    task automatic compare_gpio(input string name, input gpio_out_t exp, input gpio_out_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: io_out expected %03h/%02h/%06h, actual %03h/%02h/%06h",
                     name, exp.red_leds, exp.green_leds, exp.hex,
                     act.red_leds, act.green_leds, act.hex);
            gpio_errors++;
        end
    endtask

    // Compares the handshake fields only
    task automatic compare_rsp(input string name, input ahb_rsp_t exp, input ahb_rsp_t act);
        if (act.hready !== exp.hready || act.hresp !== exp.hresp) begin
            $display("[FAIL] %s: hready/hresp expected %b/%b, actual %b/%b", name,
                     exp.hready, exp.hresp, act.hready, act.hresp);
            rsp_errors++;
        end
    endtask

    task automatic check_data_phase(input int idx);
        ahb_rsp_t exp_rsp;
        exp_rsp = '0;
        exp_rsp.hresp  = exp_errs[idx];
        exp_rsp.hready = exp_errs[idx] ? (err_waits > 0) : 1'b1;  // ERROR stalls one cycle
        compare_rsp(names[idx], exp_rsp, rsp);
        if (!exp_errs[idx] && ops[idx] == "R" && rsp.hready) begin
            compare_word(names[idx], words[idx], rsp.hrdata);
        end
        if (!rsp.hready) begin
            err_waits++;
        end
    endtask

    // --------------------
    // Stimulus
    // --------------------

    task automatic read_cases();
        int fd, code;
        int sz, err;
        string line, name, op;
        logic [31:0] a, d, sw, btn, red, green, hex;
        fd = $fopen("dv/matrix_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the cases file dv/matrix_cases.txt");
            other_errors++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0 || line.len() < 2 || line[0] == "#") continue;
            code = $sscanf(line, "%s %s %h %d %h %h %h %h %h %h %d",
                           name, op, a, sz, d, sw, btn, red, green, hex, err);
            if (code != 11) begin
                $display("Malformed line in the cases file: %s", line);
                other_errors++;
                continue;
            end
            names.push_back(name);
            ops.push_back(op);
            addrs.push_back(a);
            sizes.push_back(sz[2:0]);
            words.push_back(d);
            ins.push_back({sw[N_SWITCHES-1:0], btn[N_BUTTONS-1:0]});
            exp_outs.push_back({red[N_RED_LEDS-1:0], green[N_GREEN_LEDS-1:0], hex[HEX_WIDTH-1:0]});
            exp_errs.push_back(err != 0);
        end
        $fclose(fd);
    endtask

    task automatic drive_address(input int idx);
        req.haddr  = addrs[idx];
        req.hsize  = sizes[idx];
        req.hwrite = (ops[idx] == "W");
        req.htrans = (ops[idx] == "I") ? HTRANS_IDLE : HTRANS_NONSEQ;
        io_in      = ins[idx];
    endtask

    always @(posedge hclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        ahb_rsp_t reset_rsp;
        req    = '0;
        hwdata = '0;
        io_in  = '0;
        word_errors  = 0;
        gpio_errors  = 0;
        rsp_errors   = 0;
        other_errors = 0;
        read_cases();
        cycle_limit = RESET_CYCLES + 4 * names.size() + 50;

        wait (rst_n);
        reset_rsp        = '0;
        reset_rsp.hready = 1'b1;
        compare_rsp("reset", reset_rsp, rsp);
        compare_gpio("reset", '0, io_out);

        addr_idx   = -1;
        data_idx   = -1;
        done_idx   = -1;
        next_case  = 0;
        last_ready = 1'b1;
        // Address phase of one case overlaps the data phase of the one before
        while (next_case < names.size() || addr_idx >= 0 || data_idx >= 0 || done_idx >= 0) begin
            @(negedge hclk);
            if (done_idx >= 0) begin
                compare_gpio(names[done_idx], exp_outs[done_idx], io_out);
                done_idx = -1;
            end
            if (last_ready) begin
                data_idx  = addr_idx;
                err_waits = 0;
                if (data_idx >= 0 && ops[data_idx] == "W") begin
                    hwdata = words[data_idx];
                end
                if (next_case < names.size()) begin
                    addr_idx = next_case;
                    next_case++;
                    drive_address(addr_idx);
                end else begin
                    addr_idx   = -1;
                    req.htrans = HTRANS_IDLE;
                end
            end
            if (data_idx >= 0) begin
                check_data_phase(data_idx);
                if (rsp.hready) done_idx = data_idx;
            end
            last_ready = rsp.hready;
        end

        $display("Cases %0d, errors: word %0d, gpio %0d, response %0d, other %0d",
                 names.size(), word_errors, gpio_errors, rsp_errors, other_errors);
        if (word_errors + gpio_errors + rsp_errors + other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* dv/matrix_cases.txt */
# name op addr hsize data switches buttons exp_red exp_green exp_hex exp_err
# op: W writes data, R expects data as read word, I idle; hsize 0 byte, 1 half, 2 word
idle_after_reset  I 00000000 2 00000000 000 0 000 00 000000 0
rr_word_w0        W 1fc00000 2 11223344 000 0 000 00 000000 0
ram_word_w0       W 00000000 2 a5a5a5a5 000 0 000 00 000000 0
rr_word_r0        R 1fc00000 2 11223344 000 0 000 00 000000 0
ram_word_r0       R 00000000 2 a5a5a5a5 000 0 000 00 000000 0
rr_word_w10       W 1fc00010 2 deadbeef 000 0 000 00 000000 0
ram_word_w10      W 00000010 2 01234567 000 0 000 00 000000 0
rr_word_r10       R 1fc00010 2 deadbeef 000 0 000 00 000000 0
ram_word_r10      R 00000010 2 01234567 000 0 000 00 000000 0
ram_word_w_top    W 00000ffc 2 0badf00d 000 0 000 00 000000 0
ram_word_r_top    R 00000ffc 2 0badf00d 000 0 000 00 000000 0
ram_word_w20      W 00000020 2 00000000 000 0 000 00 000000 0
ram_byte_w0       W 00000020 0 777777aa 000 0 000 00 000000 0
ram_byte_w1       W 00000021 0 6666bb66 000 0 000 00 000000 0
ram_byte_w2       W 00000022 0 55cc5555 000 0 000 00 000000 0
ram_byte_w3       W 00000023 0 dd444444 000 0 000 00 000000 0
idle_before_r20   I 00000000 2 00000000 000 0 000 00 000000 0
ram_merged_r20    R 00000020 2 ddccbbaa 000 0 000 00 000000 0
rr_word_w40       W 1fc00040 2 12345678 000 0 000 00 000000 0
rr_half_w0        W 1fc00040 1 9999abcd 000 0 000 00 000000 0
rr_half_w2        W 1fc00042 1 ef015555 000 0 000 00 000000 0
idle_before_r40   I 00000000 2 00000000 000 0 000 00 000000 0
rr_merged_r40     R 1fc00040 2 ef01abcd 000 0 000 00 000000 0
ram_word_w30      W 00000030 2 ffffffff 000 0 000 00 000000 0
ram_byte_w31      W 00000031 0 12345678 000 0 000 00 000000 0
ram_fwd_r31       R 00000030 2 ffff56ff 000 0 000 00 000000 0
ram_half_w32      W 00000032 1 0000c3c3 000 0 000 00 000000 0
ram_fwd_r32       R 00000030 2 000056ff 000 0 000 00 000000 0
ram_byte_w33      W 00000033 0 80000000 000 0 000 00 000000 0
ram_fwd_r33       R 00000030 2 800056ff 000 0 000 00 000000 0
gpio_red_w        W 1f800000 2 12345abc 000 0 2bc 00 000000 0
gpio_green_w      W 1f800004 2 000001a5 000 0 2bc a5 000000 0
gpio_hex_w        W 1f800008 2 ff123456 000 0 2bc a5 123456 0
gpio_red_r        R 1f800000 2 000002bc 000 0 2bc a5 123456 0
gpio_green_r      R 1f800004 2 000000a5 000 0 2bc a5 123456 0
gpio_hex_r        R 1f800008 2 00123456 000 0 2bc a5 123456 0
gpio_switches_r   R 1f80000c 2 00000155 155 0 2bc a5 123456 0
gpio_buttons_r    R 1f800010 2 0000000a 155 a 2bc a5 123456 0
gpio_switches_w   W 1f80000c 2 ffffffff 2aa 5 2bc a5 123456 0
gpio_switches_r2  R 1f80000c 2 000002aa 2aa 5 2bc a5 123456 0
gpio_unknown_r    R 1f800014 2 00000000 000 0 2bc a5 123456 0
err_write         W 10401000 2 cafef00d 000 0 2bc a5 123456 1
ram_after_err_w   R 00000000 2 a5a5a5a5 000 0 2bc a5 123456 0
err_read          R 10401000 2 00000000 000 0 2bc a5 123456 1
rr_after_err_r    R 1fc00000 2 11223344 000 0 2bc a5 123456 0
idle_end          I 00000000 2 00000000 000 0 2bc a5 123456 0

/* sources.f */
logic/mfp_ahb_pkg.sv
logic/mfp_ahb_lite_decoder.sv
logic/mfp_ahb_lite_response_mux.sv
logic/ahb_lite_bram.sv
logic/mfp_ahb_gpio_slave.sv
logic/mfp_ahb_lite_matrix.sv
dv/clock_gen.sv
dv/tb_mfp_ahb_lite_matrix.sv
